// File: Makefile
SIM := verilator
FLAGS := --binary --timing --assert
TOP := tbCpu
FLIST := flist.f

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

// File: cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequential 16-bit core top level
// fetch, decode, execute, result stages
// register file beside the stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cpu (
	input logic clk,
	input logic rstN,
	output logic fetchReq,
	output logic [cpuPkg::dataW-1:0] fetchAddr,
	input logic fetchAck,
	input logic [cpuPkg::dataW-1:0] fetchData,
	output logic [cpuPkg::dataW-1:0] pc,
	output logic hlt,
	output logic wbValid,
	output logic [cpuPkg::regAddrW-1:0] wbReg,
	output logic [cpuPkg::dataW-1:0] wbData
);
	import cpuPkg::*;

	instrWord instr;
	logic instrValid;
	logic [dataW-1:0] pcPlus2;
	logic commit, halt; // result stage back to fetch
	logic [dataW-1:0] nextPc;
	logic [regAddrW-1:0] rdAddrA, rdAddrB;
	logic [dataW-1:0] rdDataA, rdDataB;
	logic wrEn;
	logic [regAddrW-1:0] wrAddr;
	logic [dataW-1:0] wrData;

	decExIf dex ();
	exResIf exr ();

	fetchCtrl uFetch (.clk(clk), .rstN(rstN), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.fetchAck(fetchAck), .fetchData(fetchData), .pc(pc), .hlt(hlt), .instr(instr),
		.instrValid(instrValid), .pcPlus2(pcPlus2), .commit(commit), .nextPc(nextPc),
		.halt(halt));

	regFile uRegs (.clk(clk), .rstN(rstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.rdDataA(rdDataA), .rdDataB(rdDataB), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData));

	decodeStage uDec (.clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid),
		.pcPlus2(pcPlus2), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA),
		.rdDataB(rdDataB), .dex(dex.dec));

	executeStage uEx (.clk(clk), .rstN(rstN), .dex(dex.ex), .exr(exr.ex));

	resultStage uRes (.clk(clk), .rstN(rstN), .exr(exr.res), .wrEn(wrEn), .wrAddr(wrAddr),
		.wrData(wrData), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.commit(commit), .nextPc(nextPc), .halt(halt));
endmodule

// File: cpuPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths for the sequential core
// opcode and branch condition codes
// instruction word union, three layouts
// flag bit positions, fetch FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuPkg;
	localparam int dataW = 16; // data word and pc width
	localparam int regAddrW = 4; // 16 registers
	localparam int opW = 4; // opcode field, bits 15:12
	localparam int condW = 3; // branch condition field
	localparam int flagW = 3; // Z, V, N
	localparam int fsmW = 2; // fetch FSM state width
	localparam logic [dataW-1:0] pcStep = 16'd2; // byte addressed words

	localparam logic [opW-1:0] opAdd = 4'h0; // saturating
	localparam logic [opW-1:0] opSub = 4'h1; // saturating
	localparam logic [opW-1:0] opXor = 4'h2;
	localparam logic [opW-1:0] opSll = 4'h4;
	localparam logic [opW-1:0] opSra = 4'h5;
	localparam logic [opW-1:0] opRor = 4'h6;
	localparam logic [opW-1:0] opLlb = 4'ha;
	localparam logic [opW-1:0] opLhb = 4'hb;
	localparam logic [opW-1:0] opB = 4'hc; // pc relative, conditional
	localparam logic [opW-1:0] opBr = 4'hd; // register target
	localparam logic [opW-1:0] opPcs = 4'he;
	localparam logic [opW-1:0] opHlt = 4'hf;

	localparam logic [condW-1:0] condNe = 3'b000; // Z clear
	localparam logic [condW-1:0] condEq = 3'b001; // Z set
	localparam logic [condW-1:0] condGt = 3'b010; // Z and N clear
	localparam logic [condW-1:0] condLt = 3'b011; // N set
	localparam logic [condW-1:0] condGe = 3'b100;
	localparam logic [condW-1:0] condLe = 3'b101;
	localparam logic [condW-1:0] condOv = 3'b110; // V set
	localparam logic [condW-1:0] condAl = 3'b111; // unconditional

	localparam int flagZ = 2; // flag word is {Z, V, N}
	localparam int flagV = 1;
	localparam int flagN = 0;

	localparam logic [fsmW-1:0] stIdle = 2'd0; // after reset or halted
	localparam logic [fsmW-1:0] stRequest = 2'd1; // fetchReq high
	localparam logic [fsmW-1:0] stRelease = 2'd2; // waiting for ack low
	localparam logic [fsmW-1:0] stBusy = 2'd3; // instruction in flight

	typedef union packed {
		struct packed {
			logic [opW-1:0] op;
			logic [regAddrW-1:0] rd;
			logic [regAddrW-1:0] rs;
			logic [regAddrW-1:0] rt; // also shift amount
		} rType;
		struct packed {
			logic [opW-1:0] op;
			logic [regAddrW-1:0] rd;
			logic [7:0] imm8; // LLB / LHB byte
		} iType;
		struct packed {
			logic [opW-1:0] op;
			logic [condW-1:0] cond;
			logic [8:0] imm9; // signed word offset
		} bType;
	} instrWord;
endpackage

// File: decodeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode class decode on the union views
// register operand read, immediate forming
// registered hand-off into decExIf
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decodeStage (
	input logic clk,
	input logic rstN,
	input cpuPkg::instrWord instr,
	input logic instrValid,
	input logic [cpuPkg::dataW-1:0] pcPlus2,
	output logic [cpuPkg::regAddrW-1:0] rdAddrA,
	output logic [cpuPkg::regAddrW-1:0] rdAddrB,
	input logic [cpuPkg::dataW-1:0] rdDataA,
	input logic [cpuPkg::dataW-1:0] rdDataB,
	decExIf.dec dex
);
	import cpuPkg::*;

	logic [dataW-1:0] immNext; // formed immediate

	always_comb begin
		rdAddrA = instr.rType.rs; // rs, also the BR target register
		rdAddrB = instr.rType.rt;
		immNext = '0;
		case (instr.rType.op)
			opSll, opSra, opRor: begin
				immNext = {{(dataW-regAddrW){1'b0}}, instr.rType.rt}; // shift amount
			end
			opLlb: begin
				rdAddrB = instr.iType.rd; // old rd value gets merged
				immNext = {8'h00, instr.iType.imm8}; // low byte lane
			end
			opLhb: begin
				rdAddrB = instr.iType.rd;
				immNext = {instr.iType.imm8, 8'h00}; // high byte lane
			end
			opB: begin
				// sign extend, word offset to byte offset
				immNext = {{(dataW-10){instr.bType.imm9[8]}}, instr.bType.imm9, 1'b0};
			end
			default: immNext = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			dex.valid <= 1'b0;
		else
			dex.valid <= instrValid; // stays a single pulse
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			dex.op <= instr.rType.op;
			dex.cond <= instr.bType.cond; // only meaningful for B
			dex.aVal <= rdDataA;
			dex.bVal <= rdDataB;
			dex.imm <= immNext;
			dex.dst <= instr.iType.rd; // same field in r and i layouts
			dex.pcPlus2 <= pcPlus2;
		end
	end
endmodule

// File: executeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturating add/sub, xor, shifter
// byte merge for LLB/LHB, PCS
// ZVN flag register with per-op enables
// branch condition and target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module executeStage (
	input logic clk,
	input logic rstN,
	decExIf.ex dex,
	exResIf.ex exr
);
	import cpuPkg::*;

	logic [flagW-1:0] flags; // {Z, V, N}
	logic [flagW-1:0] newFlags, flagWe;
	logic [dataW-1:0] sum, diff, result;
	logic [2*dataW-1:0] rotW; // doubled word for ror
	logic [$clog2(dataW)-1:0] shAmt;
	logic addOv, subOv, ovf;
	logic condMet, taken, regWe;
	logic [dataW-1:0] target;

	assign sum = dex.aVal + dex.bVal;
	assign diff = dex.aVal - dex.bVal;
	assign addOv = (dex.aVal[dataW-1] == dex.bVal[dataW-1]) && (sum[dataW-1] != dex.aVal[dataW-1]);
	assign subOv = (dex.aVal[dataW-1] != dex.bVal[dataW-1]) && (diff[dataW-1] != dex.aVal[dataW-1]);
	assign shAmt = dex.imm[$clog2(dataW)-1:0];
	assign rotW = {dex.aVal, dex.aVal} >> shAmt;

	// condition test uses flags from earlier instructions
	always_comb begin
		condMet = 1'b0;
		case (dex.cond)
			condNe: condMet = !flags[flagZ];
			condEq: condMet = flags[flagZ];
			condGt: condMet = !flags[flagZ] && !flags[flagN];
			condLt: condMet = flags[flagN];
			condGe: condMet = flags[flagZ] || !flags[flagN];
			condLe: condMet = flags[flagZ] || flags[flagN];
			condOv: condMet = flags[flagV];
			condAl: condMet = 1'b1;
		endcase
	end

	always_comb begin
		result = dex.aVal ^ dex.bVal;
		ovf = 1'b0;
		regWe = 1'b0;
		flagWe = '0; // flags hold unless enabled
		taken = 1'b0;
		target = dex.pcPlus2 + dex.imm; // B target
		case (dex.op)
			opAdd: begin
				ovf = addOv;
				result = addOv ? {dex.aVal[dataW-1], {(dataW-1){!dex.aVal[dataW-1]}}} : sum;
				regWe = 1'b1;
				flagWe = '1;
			end
			opSub: begin
				ovf = subOv;
				result = subOv ? {dex.aVal[dataW-1], {(dataW-1){!dex.aVal[dataW-1]}}} : diff;
				regWe = 1'b1;
				flagWe = '1;
			end
			opXor, opSll, opSra, opRor: begin
				if (dex.op == opSll)
					result = dex.aVal << shAmt;
				else if (dex.op == opSra)
					result = $signed(dex.aVal) >>> shAmt;
				else if (dex.op == opRor)
					result = rotW[dataW-1:0];
				regWe = 1'b1;
				flagWe[flagZ] = 1'b1; // Z only
			end
			opLlb: begin
				result = {dex.bVal[dataW-1:8], dex.imm[7:0]}; // keep high byte
				regWe = 1'b1;
			end
			opLhb: begin
				result = {dex.imm[dataW-1:8], dex.bVal[7:0]}; // keep low byte
				regWe = 1'b1;
			end
			opB: taken = condMet;
			opBr: begin
				taken = 1'b1;
				target = dex.aVal;
			end
			opPcs: begin
				result = dex.pcPlus2;
				regWe = 1'b1;
			end
			default: regWe = 1'b0; // dropped opcodes and HLT
		endcase
		newFlags[flagZ] = (result == '0);
		newFlags[flagV] = ovf;
		newFlags[flagN] = result[dataW-1];
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exr.valid <= 1'b0;
			flags <= '0;
		end else begin
			exr.valid <= dex.valid;
			if (dex.valid)
				flags <= (flags & ~flagWe) | (newFlags & flagWe); // per-bit enable
		end
	end

	always_ff @(posedge clk) begin
		if (dex.valid) begin
			exr.regWe <= regWe;
			exr.dst <= dex.dst;
			exr.result <= result;
			exr.taken <= taken;
			exr.target <= target;
			exr.halt <= (dex.op == opHlt);
			exr.pcPlus2 <= dex.pcPlus2;
		end
	end
endmodule

// File: fetchCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc register and halt latch
// four-phase req/ack fetch FSM
// one instruction in flight at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetchCtrl (
	input logic clk,
	input logic rstN,
	output logic fetchReq,
	output logic [cpuPkg::dataW-1:0] fetchAddr,
	input logic fetchAck,
	input logic [cpuPkg::dataW-1:0] fetchData,
	output logic [cpuPkg::dataW-1:0] pc,
	output logic hlt,
	output cpuPkg::instrWord instr,
	output logic instrValid,
	output logic [cpuPkg::dataW-1:0] pcPlus2,
	input logic commit,
	input logic [cpuPkg::dataW-1:0] nextPc,
	input logic halt
);
	import cpuPkg::*;

	logic [fsmW-1:0] state;

	assign fetchReq = (state == stRequest); // drops as soon as ack seen
	assign fetchAddr = pc; // stable, pc only moves in busy
	assign instrValid = (state == stRelease) && !fetchAck; // phase 4 done
	assign pcPlus2 = pc + pcStep;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			pc <= '0;
			hlt <= 1'b0;
		end else begin
			case (state)
				stIdle: if (!hlt) state <= stRequest; // never leaves once halted
				stRequest: if (fetchAck) state <= stRelease; // data latched below
				stRelease: if (!fetchAck) state <= stBusy;
				stBusy: begin
					if (commit && halt) begin
						hlt <= 1'b1; // pc stays on the HLT word
						state <= stIdle;
					end else if (commit) begin
						pc <= nextPc;
						state <= stRequest; // next fetch the cycle after commit
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// instruction word capture while req and ack are both high
	always_ff @(posedge clk) begin
		if (state == stRequest && fetchAck)
			instr <= fetchData;
	end
endmodule

// File: flist.f
+incdir+.
cpuPkg.sv
stageIfs.sv
fetchCtrl.sv
regFile.sv
decodeStage.sv
executeStage.sv
resultStage.sv
cpu.sv
tbCpu.sv

// File: regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16 x 16 register file
// two async read ports, one write port
// r0 reads as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module regFile (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::regAddrW-1:0] rdAddrA,
	input logic [cpuPkg::regAddrW-1:0] rdAddrB,
	output logic [cpuPkg::dataW-1:0] rdDataA,
	output logic [cpuPkg::dataW-1:0] rdDataB,
	input logic wrEn,
	input logic [cpuPkg::regAddrW-1:0] wrAddr,
	input logic [cpuPkg::dataW-1:0] wrData
);
	import cpuPkg::*;

	logic [dataW-1:0] regs [2**regAddrW];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**regAddrW; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin // r0 never written
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA]; // hard zero
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];
endmodule

// File: resultStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register write and write-back trace
// next pc select, halt hand-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module resultStage (
	input logic clk,
	input logic rstN,
	exResIf.res exr,
	output logic wrEn,
	output logic [cpuPkg::regAddrW-1:0] wrAddr,
	output logic [cpuPkg::dataW-1:0] wrData,
	output logic wbValid,
	output logic [cpuPkg::regAddrW-1:0] wbReg,
	output logic [cpuPkg::dataW-1:0] wbData,
	output logic commit,
	output logic [cpuPkg::dataW-1:0] nextPc,
	output logic halt
);
	logic halted; // HLT has retired
	logic retire;

	assign retire = exr.valid && !halted; // architectural state frozen after HLT

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			halted <= 1'b0;
		else if (retire && exr.halt)
			halted <= 1'b1;
	end

	assign wrEn = retire && exr.regWe;
	assign wrAddr = exr.dst;
	assign wrData = exr.result;
	assign wbValid = retire; // one pulse per retired instruction
	assign wbReg = exr.dst;
	assign wbData = exr.result;
	assign commit = retire;
	assign nextPc = exr.taken ? exr.target : exr.pcPlus2;
	assign halt = exr.halt;
endmodule

// File: stageIfs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decExIf  decode to execute bundle
// exResIf  execute to result bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface decExIf;
	import cpuPkg::*;

	logic valid; // one-cycle pulse
	logic [opW-1:0] op;
	logic [condW-1:0] cond;
	logic [dataW-1:0] aVal; // rs value
	logic [dataW-1:0] bVal; // rt, or rd for byte loads
	logic [dataW-1:0] imm; // already formed per class
	logic [regAddrW-1:0] dst;
	logic [dataW-1:0] pcPlus2;

	modport dec (
		output valid, op, cond, aVal, bVal, imm, dst, pcPlus2
	);

	modport ex (
		input valid, op, cond, aVal, bVal, imm, dst, pcPlus2
	);
endinterface

interface exResIf;
	import cpuPkg::*;

	logic valid; // one-cycle pulse
	logic regWe; // rd gets written
	logic [regAddrW-1:0] dst;
	logic [dataW-1:0] result;
	logic taken; // branch redirect
	logic [dataW-1:0] target;
	logic halt;
	logic [dataW-1:0] pcPlus2; // fall-through pc

	modport ex (
		output valid, regWe, dst, result, taken, target, halt, pcPlus2
	);

	modport res (
		input valid, regWe, dst, result, taken, target, halt, pcPlus2
	);
endinterface

// File: cpuModel.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of the instruction set
// random program generator, forward only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
logic [15:0] prog [256]; // program image, word indexed
bit noLand [256]; // LHB and BR words of a BR group
logic [15:0] mRegs [16];
logic mZ, mV, mN; // model flags
logic [15:0] mPc;
int mCount; // retired instructions
bit mHalted;

// first word at or after t that a branch may land on
function automatic int landing(input int t);
	int u;
	u = (t > 255) ? 255 : t;
	while (noLand[u])
		u++; // word 255 is never marked
	return u;
endfunction

task automatic genProgram();
	instrWord w;
	int i;
	int t;
	logic [3:0] r;
	logic [15:0] addr;
	i = 0;
	while (i < 255) begin
		w = 16'($urandom);
		if (w.rType.op == opHlt)
			w.rType.op = opBr; // HLT only as the last word
		if (w.rType.op == opBr && i < 252) begin
			r = 4'($urandom_range(15, 1));
			prog[i] = {opLlb, r, 8'h00}; // target bytes filled in below
			prog[i + 1] = {opLhb, r, 8'h00};
			prog[i + 2] = {opBr, 4'h0, r, 4'h0};
			noLand[i + 1] = 1'b1;
			noLand[i + 2] = 1'b1;
			i += 3;
		end else begin
			if (w.rType.op == opBr)
				w.rType.op = opPcs; // no room left for a group
			prog[i] = w;
			i++;
		end
	end
	prog[255] = {opHlt, 12'h000};
	// every target lies ahead, so each program reaches HLT
	for (i = 0; i < 255; i++) begin
		w = prog[i];
		if (w.rType.op == opB) begin
			t = landing(i + 1 + int'($urandom % 8));
			w.bType.imm9 = 9'(t - i - 1); // word offset from pc + 2
			prog[i] = w;
		end else if (w.rType.op == opLlb && noLand[i + 1]) begin
			addr = 16'(2 * landing(i + 3 + int'($urandom % 8)));
			w.iType.imm8 = addr[7:0];
			prog[i] = w;
			w = prog[i + 1];
			w.iType.imm8 = addr[15:8];
			prog[i + 1] = w;
		end
	end
endtask

task automatic resetModel();
	for (int i = 0; i < 16; i++)
		mRegs[i] = '0;
	{mZ, mV, mN} = 3'b000;
	mPc = '0;
	mCount = 0;
	mHalted = 1'b0;
endtask

function automatic bit condHolds(input logic [2:0] c);
	case (c)
		condNe: return !mZ;
		condEq: return mZ;
		condGt: return !mZ && !mN;
		condLt: return mN;
		condGe: return mZ || !mN;
		condLe: return mZ || mN;
		condOv: return mV;
		default: return 1'b1; // always
	endcase
endfunction

// retire the instruction at mPc
task automatic stepModel(output logic [3:0] rd, output logic [15:0] r,
	output logic [3:0] op);
	instrWord w;
	logic [15:0] a, b, nextPc;
	int s;
	bit we; // rd gets written
	w = prog[mPc[8:1]];
	op = w.rType.op;
	rd = w.rType.rd;
	a = mRegs[w.rType.rs]; // r0 is never written
	b = mRegs[w.rType.rt];
	we = 1'b1;
	r = '0;
	nextPc = mPc + 16'd2;
	case (op)
		opAdd, opSub: begin
			s = (op == opAdd) ? int'($signed(a)) + int'($signed(b))
				: int'($signed(a)) - int'($signed(b)); // exact sum, no wrap
			mV = (s > 32767) || (s < -32768);
			r = (s > 32767) ? 16'h7fff : (s < -32768) ? 16'h8000 : 16'(s);
			mN = r[15];
		end
		opXor: r = a ^ b;
		opSll: r = a << w.rType.rt;
		opSra: r = $signed(a) >>> w.rType.rt;
		opRor: begin
			r = a;
			for (int k = 0; k < int'(w.rType.rt); k++)
				r = {r[0], r[15:1]}; // one bit per step
		end
		opLlb: r = {mRegs[rd][15:8], w.iType.imm8};
		opLhb: r = {w.iType.imm8, mRegs[rd][7:0]};
		opPcs: r = mPc + 16'd2;
		default: we = 1'b0; // branches, HLT, dropped opcodes
	endcase
	if (op inside {opAdd, opSub, opXor, opSll, opSra, opRor})
		mZ = (r == 16'h0000);
	if (op == opB && condHolds(w.bType.cond))
		nextPc = mPc + 16'd2 + {{6{w.bType.imm9[8]}}, w.bType.imm9, 1'b0};
	if (op == opBr)
		nextPc = a;
	if (op == opHlt) begin
		mHalted = 1'b1;
		nextPc = mPc; // pc freezes on the HLT word
	end
	if (we && rd != 4'h0)
		mRegs[rd] = r;
	mPc = nextPc;
	mCount++;
endtask

// File: tbCpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sequential core
// clock, reset, four-phase fetch responder
// model compare on every write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbCpu;
	import cpuPkg::*;

	logic clk = 1'b0;
	logic rstN, fetchAck, fetchReq, hlt, wbValid;
	logic [15:0] fetchData, fetchAddr, pc, wbData;
	logic [3:0] wbReg;
	int errs [6]; // per behavior
	int nChecks, dutCount;
	string testName [6] = '{"reset", "handshake", "alu results", "byte loads and pcs",
		"branches", "halt"};

	`include "cpuModel.svh"

	cpu DUT (.clk(clk), .rstN(rstN), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.fetchAck(fetchAck), .fetchData(fetchData), .pc(pc), .hlt(hlt),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

	always #50 clk = !clk; // period 100

	// every wbValid pulse the DUT shows, whenever it comes
	always @(negedge clk) begin
		if (wbValid)
			dutCount++;
	end

	task automatic verify(input bit ok, input int cat, input string msg);
		nChecks++;
		assert (ok) else begin
			$display("mismatch at %0t: %s", $time, msg);
			errs[cat]++;
		end
	endtask

	task automatic abortRun(input string what);
		$display("timeout at %0t: no %s", $time, what);
		$display("** FAIL **");
		$finish;
	endtask

	// 0 to 4 cycles with fetchAck held
	task automatic holdCycles(input bit ackHigh, input logic [15:0] addr);
		int n;
		n = $urandom % 5;
		repeat (n) begin
			@(negedge clk);
			if (ackHigh)
				verify(!fetchReq, 1, "fetchReq high again while fetchAck still high");
			else
				verify(fetchReq && fetchAddr == addr && pc == addr, 1,
					$sformatf("fetchAddr %h pc %h moved from %h", fetchAddr, pc, addr));
		end
	endtask

	task automatic serveFetch(input bit afterBranch);
		int t;
		logic [15:0] addr;
		t = 0;
		while (!fetchReq && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (!fetchReq)
			abortRun("fetchReq within 20 cycles");
		addr = fetchAddr;
		verify(addr == mPc, 1, $sformatf("fetchAddr %h, model pc %h", addr, mPc));
		if (afterBranch)
			verify(addr == mPc, 4, $sformatf("branch went to %h, model %h", addr, mPc));
		holdCycles(1'b0, addr);
		fetchAck = 1'b1;
		fetchData = prog[addr[8:1]];
		t = 0;
		do begin
			@(negedge clk);
			t++;
			if (fetchReq)
				verify(fetchAddr == addr, 1, "fetchAddr moved with fetchReq high");
		end while (fetchReq && t < 20);
		if (fetchReq)
			abortRun("fetchReq drop within 20 cycles of fetchAck");
		holdCycles(1'b1, addr);
		fetchAck = 1'b0; // phase 4
	endtask

	task automatic awaitRetire();
		int t;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!wbValid && t < 20);
		if (!wbValid)
			abortRun("wbValid within 20 cycles of the fetch");
	endtask

	initial begin
		bit wasBranch;
		logic [3:0] rd, op;
		logic [15:0] val;
		int total;
		void'($urandom(32'h910cadd9)); // single seed for the run
		rstN = 1'b0;
		fetchAck = 1'b0;
		fetchData = '0;
		genProgram();
		resetModel();
		repeat (16) begin
			@(negedge clk);
			verify(!fetchReq && !hlt && !wbValid && pc == '0, 0, "outputs active in reset");
		end
		rstN = 1'b1;
		verify(!fetchReq && !hlt && !wbValid && pc == '0, 0, "outputs active at release");
		$display("%s: %0d errors", testName[0], errs[0]);
		wasBranch = 1'b0;
		while (!mHalted && mCount < 1000) begin
			serveFetch(wasBranch);
			awaitRetire();
			stepModel(rd, val, op);
			if (op inside {opAdd, opSub, opXor, opSll, opSra, opRor})
				verify(wbReg == rd && wbData == val, 2, $sformatf("op %h r%0d=%h, got r%0d=%h",
					op, rd, val, wbReg, wbData));
			else if (op inside {opLlb, opLhb, opPcs})
				verify(wbReg == rd && wbData == val, 3, $sformatf("op %h r%0d=%h, got r%0d=%h",
					op, rd, val, wbReg, wbData));
			wasBranch = (op == opB || op == opBr); // next fetchAddr shows the decision
		end
		if (!mHalted)
			abortRun("HLT retired within 1000 instructions");
		repeat (50) begin
			@(negedge clk);
			verify(hlt && !fetchReq && pc == mPc, 5,
				$sformatf("after HLT hlt %b fetchReq %b pc %h", hlt, fetchReq, pc));
		end
		@(posedge clk); // pulse counter has seen the last negedge
		verify(dutCount == mCount, 5, $sformatf("retired %0d, model %0d", dutCount, mCount));
		total = errs[0];
		for (int i = 1; i < 6; i++) begin
			$display("%s: %0d errors", testName[i], errs[i]);
			total += errs[i];
		end
		$display("checks %0d, errors %0d, retired %0d", nChecks, total, dutCount);
		if (total == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule
